// ==== common/mrr_pkg.sv ====
`default_nettype none

package mrr_pkg;

    // sample and cycle framing
    localparam int ESAMP_WIDTH = 16;
    localparam int OVERSAMPLING = 4;
    localparam int SAMP_CNT_WIDTH = $clog2(OVERSAMPLING);
    localparam logic [SAMP_CNT_WIDTH-1:0] SAMP_LAST = SAMP_CNT_WIDTH'(OVERSAMPLING - 1);
    localparam int CYC_WIDTH = 5;
    localparam int ACC_WIDTH = ESAMP_WIDTH + 4;

    // preamble and offset search
    localparam int PN_SEQ_LEN = 15;
    localparam logic [PN_SEQ_LEN-1:0] PN_SEQ = 15'b000100110101111;
    localparam int SEARCH_LEN = 16;
    localparam int SEARCH_AWIDTH = $clog2(SEARCH_LEN);
    localparam int CHIP_CNT_WIDTH = 4;
    localparam int CORR_WIDTH = 6;
    localparam int BUF_DEPTH = PN_SEQ_LEN + SEARCH_LEN;
    localparam int BUF_AWIDTH = 5;

    // packet fields
    localparam int CHIP_ID_LEN = 16;
    localparam int MESSAGE_LEN = 32;
    localparam int BIT_CNT_WIDTH = 9;
    // four mrr cycles per transmitted bit
    localparam int TX_CYCLES = MESSAGE_LEN * 4;

    typedef enum logic [2:0] {
        ST_IDLE, ST_RX, ST_POP, ST_TURNAROUND, ST_TX
    } rx_state_e;

    typedef enum logic [2:0] {
        SRCH_IDLE, SRCH_CORR, SRCH_DRAIN, SRCH_NEXT, SRCH_DONE
    } search_state_e;

endpackage

`default_nettype wire

// ==== common/decision_if.sv ====
`default_nettype none

interface decision_if;
    // write side, one strobe per decided symbol
    logic                            wr_en;
    logic [mrr_pkg::BUF_AWIDTH-1:0] wr_addr;
    logic                            wr_bit;
    // read side, data returns one clock after the address
    logic [mrr_pkg::BUF_AWIDTH-1:0] rd_addr;
    logic                            rd_bit;

    modport producer (output wr_en, output wr_addr, output wr_bit);
    modport buffer (
        input wr_en, input wr_addr, input wr_bit, input rd_addr, output rd_bit
    );
    modport consumer (output rd_addr, input rd_bit);
endinterface

`default_nettype wire

// ==== demod/chip_demodulator.sv ====
`default_nettype none

module chip_demodulator (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                i_rx_en,
    input  wire logic                                i_sample_valid,
    input  wire logic [mrr_pkg::ESAMP_WIDTH-1:0]     i_sample,
    input  wire logic [3:0]                          i_recharge_len,
    decision_if.producer                             dec,
    output logic                                     o_buffer_full,
    output logic [mrr_pkg::BIT_CNT_WIDTH-1:0]        o_bit_count,
    output logic [mrr_pkg::CHIP_ID_LEN-1:0]          o_chip_id
);

    logic [mrr_pkg::SAMP_CNT_WIDTH-1:0] samp_cnt;
    logic [mrr_pkg::CYC_WIDTH-1:0]      cyc;
    logic [mrr_pkg::CYC_WIDTH-1:0]      last_cyc;
    logic [mrr_pkg::ACC_WIDTH-1:0]      zero_sum;
    logic [mrr_pkg::ACC_WIDTH-1:0]      one_sum;
    logic [mrr_pkg::ACC_WIDTH-1:0]      sample_ext;
    logic                               cycle_end;
    logic                               dec_pending;
    logic                               dec_bit;
    logic                               in_buffer;

    assign sample_ext = {{(mrr_pkg::ACC_WIDTH - mrr_pkg::ESAMP_WIDTH){1'b0}}, i_sample};
    assign cycle_end  = i_sample_valid && (samp_cnt == mrr_pkg::SAMP_LAST);
    // symbol is cycles 0 .. recharge_len+2
    assign last_cyc   = {1'b0, i_recharge_len} + 5'd2;

    assign dec_bit   = one_sum > zero_sum;
    assign in_buffer = o_bit_count < mrr_pkg::BUF_DEPTH;

    assign dec.wr_en   = dec_pending && in_buffer;
    assign dec.wr_addr = o_bit_count[mrr_pkg::BUF_AWIDTH-1:0];
    assign dec.wr_bit  = dec_bit;

    // last stored decision hands the buffer to the search
    assign o_buffer_full = dec_pending && (o_bit_count == mrr_pkg::BUF_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (rst || !i_rx_en) begin
            samp_cnt    <= '0;
            cyc         <= '0;
            zero_sum    <= '0;
            one_sum     <= '0;
            dec_pending <= 1'b0;
            o_bit_count <= '0;
        end else begin
            // decide one clock after the strobe closing cycle 6
            dec_pending <= cycle_end && (cyc == 5'd6);

            if (i_sample_valid) begin
                samp_cnt <= cycle_end ? '0 : samp_cnt + 1'b1;
                if (cyc == 5'd3 || cyc == 5'd4) begin
                    zero_sum <= zero_sum + sample_ext;
                end
                if (cyc == 5'd5 || cyc == 5'd6) begin
                    one_sum <= one_sum + sample_ext;
                end
            end

            if (cycle_end) begin
                cyc <= (cyc == last_cyc) ? '0 : cyc + 1'b1;
            end

            // recharge cycles follow, so no sample lands on a cleared sum
            if (dec_pending) begin
                zero_sum    <= '0;
                one_sum     <= '0;
                o_bit_count <= o_bit_count + 1'b1;
            end
        end
    end

    // newest decision enters at the msb
    always_ff @(posedge clk) begin
        if (dec_pending) begin
            o_chip_id <= {dec_bit, o_chip_id[mrr_pkg::CHIP_ID_LEN-1:1]};
        end
    end

    // cycles 5 and 6 must fit inside the symbol
    a_recharge_min: assert property (
        @(posedge clk) disable iff (rst)
        i_rx_en |-> (i_recharge_len >= 4'd5)
    );

endmodule

`default_nettype wire

// ==== logic/decision_buffer.sv ====
`default_nettype none

module decision_buffer (
    input wire logic   clk,
    decision_if.buffer bus
);

    // one hard bit per early symbol
    logic mem [mrr_pkg::BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_bit;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        bus.rd_bit <= mem[bus.rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/pn_search.sv ====
`default_nettype none

module pn_search (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          i_rx_en,
    input  wire logic                          i_buffer_full,
    decision_if.consumer                       rd,
    output logic [mrr_pkg::BUF_AWIDTH-1:0]     o_offset,
    output logic                               o_offset_valid
);

    mrr_pkg::search_state_e state;

    logic [mrr_pkg::SEARCH_AWIDTH-1:0]    off_idx;
    logic [mrr_pkg::SEARCH_AWIDTH-1:0]    best_idx;
    logic [mrr_pkg::CHIP_CNT_WIDTH-1:0]   chip_idx;
    logic signed [mrr_pkg::CORR_WIDTH-1:0] corr;
    logic signed [mrr_pkg::CORR_WIDTH-1:0] best_corr;
    logic [mrr_pkg::PN_SEQ_LEN-1:0]       pn_shift;
    logic                                 acc_en_d;

    assign rd.rd_addr = {1'b0, off_idx} + {1'b0, chip_idx};

    always_ff @(posedge clk) begin
        if (rst || !i_rx_en) begin
            state          <= mrr_pkg::SRCH_IDLE;
            o_offset_valid <= 1'b0;
            acc_en_d       <= 1'b0;
        end else begin
            // read data trails the address by one clock
            acc_en_d <= (state == mrr_pkg::SRCH_CORR);
            case (state)
                mrr_pkg::SRCH_IDLE: begin
                    if (i_buffer_full) begin
                        state <= mrr_pkg::SRCH_CORR;
                    end
                end
                mrr_pkg::SRCH_CORR: begin
                    if (chip_idx == 4'(mrr_pkg::PN_SEQ_LEN - 1)) begin
                        state <= mrr_pkg::SRCH_DRAIN;
                    end
                end
                mrr_pkg::SRCH_DRAIN: begin
                    state <= mrr_pkg::SRCH_NEXT;
                end
                mrr_pkg::SRCH_NEXT: begin
                    if (off_idx == 4'(mrr_pkg::SEARCH_LEN - 1)) begin
                        state <= mrr_pkg::SRCH_DONE;
                    end else begin
                        state <= mrr_pkg::SRCH_CORR;
                    end
                end
                mrr_pkg::SRCH_DONE: begin
                    o_offset_valid <= 1'b1;
                    state          <= mrr_pkg::SRCH_IDLE;
                end
                default: state <= mrr_pkg::SRCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // +1 on agreement with the expected chip, -1 otherwise
        if (acc_en_d) begin
            pn_shift <= {pn_shift[mrr_pkg::PN_SEQ_LEN-2:0], 1'b0};
            if (rd.rd_bit == pn_shift[mrr_pkg::PN_SEQ_LEN-1]) begin
                corr <= corr + 6'sd1;
            end else begin
                corr <= corr - 6'sd1;
            end
        end

        case (state)
            mrr_pkg::SRCH_IDLE: begin
                off_idx   <= '0;
                chip_idx  <= '0;
                corr      <= '0;
                best_corr <= '0;
                best_idx  <= '0;
                pn_shift  <= mrr_pkg::PN_SEQ;
            end
            mrr_pkg::SRCH_CORR: begin
                chip_idx <= chip_idx + 1'b1;
            end
            mrr_pkg::SRCH_NEXT: begin
                // strict compare keeps the earliest of equal peaks
                if (corr > best_corr) begin
                    best_corr <= corr;
                    best_idx  <= off_idx;
                end
                corr     <= '0;
                chip_idx <= '0;
                pn_shift <= mrr_pkg::PN_SEQ;
                off_idx  <= off_idx + 1'b1;
            end
            mrr_pkg::SRCH_DONE: begin
                o_offset <= {1'b0, best_idx};
            end
            default: ;
        endcase
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (rst || !i_rx_en)
        i_buffer_full |-> (state == mrr_pkg::SRCH_IDLE)
    );

endmodule

`default_nettype wire

// ==== loopback/loopback_controller.sv ====
`default_nettype none

module loopback_controller (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                i_fm_flag,
    input  wire logic                                i_sample_valid,
    input  wire logic                                i_tx_disable,
    input  wire logic [7:0]                          i_num_payload_bits,
    input  wire logic [15:0]                         i_wait_step,
    input  wire logic [mrr_pkg::BIT_CNT_WIDTH-1:0]   i_bit_count,
    input  wire logic [mrr_pkg::CHIP_ID_LEN-1:0]     i_chip_id,
    input  wire logic [mrr_pkg::BUF_AWIDTH-1:0]      i_offset,
    input  wire logic                                i_offset_valid,
    input  wire logic                                i_pop_ack,
    input  wire logic [mrr_pkg::MESSAGE_LEN-1:0]     i_pop_message,
    output logic                                     o_rx_en,
    output logic                                     o_pop_request,
    output logic [mrr_pkg::CHIP_ID_LEN-1:0]          o_pop_chip_id,
    output logic                                     o_busy,
    output logic                                     o_detector_reset,
    output logic                                     o_tx_en,
    output logic                                     o_tx_key
);

    mrr_pkg::rx_state_e state;

    logic [mrr_pkg::SAMP_CNT_WIDTH-1:0] samp_cnt;
    logic [15:0]                        cyc_cnt;
    logic [mrr_pkg::MESSAGE_LEN-1:0]    message;
    logic [mrr_pkg::BIT_CNT_WIDTH-1:0]  rx_bits;
    logic                               cycle_start;
    logic                               cycle_end;
    logic                               cur_bit;

    // payload bits seen past the preamble
    assign rx_bits = i_bit_count
                   - {{(mrr_pkg::BIT_CNT_WIDTH - mrr_pkg::BUF_AWIDTH){1'b0}}, i_offset};

    assign cycle_start = i_sample_valid && (samp_cnt == '0);
    assign cycle_end   = i_sample_valid && (samp_cnt == mrr_pkg::SAMP_LAST);

    // during TX cyc_cnt[6:2] is the bit index and cyc_cnt[1:0] the cycle within it
    assign cur_bit = message[cyc_cnt[6:2]];

    assign o_rx_en          = (state == mrr_pkg::ST_RX);
    assign o_busy           = (state != mrr_pkg::ST_IDLE);
    assign o_detector_reset = (state == mrr_pkg::ST_TX);
    assign o_tx_en          = !i_tx_disable
                            && (state == mrr_pkg::ST_TURNAROUND || state == mrr_pkg::ST_TX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= mrr_pkg::ST_IDLE;
            o_pop_request <= 1'b0;
            o_tx_key      <= 1'b0;
            samp_cnt      <= '0;
            cyc_cnt       <= '0;
        end else begin
            if (i_sample_valid) begin
                samp_cnt <= cycle_end ? '0 : samp_cnt + 1'b1;
            end
            if (cycle_end) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end

            case (state)
                mrr_pkg::ST_IDLE: begin
                    o_tx_key <= 1'b0;
                    if (i_fm_flag) begin
                        state <= mrr_pkg::ST_RX;
                    end
                end
                mrr_pkg::ST_RX: begin
                    if (i_offset_valid && rx_bits == {1'b0, i_num_payload_bits}) begin
                        state <= mrr_pkg::ST_POP;
                    end
                end
                mrr_pkg::ST_POP: begin
                    samp_cnt <= '0;
                    cyc_cnt  <= '0;
                    if (!o_pop_request) begin
                        o_pop_request <= 1'b1;
                    end else if (i_pop_ack) begin
                        o_pop_request <= 1'b0;
                        state         <= mrr_pkg::ST_TURNAROUND;
                    end
                end
                mrr_pkg::ST_TURNAROUND: begin
                    if (cyc_cnt == i_wait_step) begin
                        samp_cnt <= '0;
                        cyc_cnt  <= '0;
                        state    <= mrr_pkg::ST_TX;
                    end
                end
                mrr_pkg::ST_TX: begin
                    // a 1 keys cycles 0 and 1 and a 0 keys cycles 2 and 3
                    if (cycle_start) begin
                        o_tx_key <= !i_tx_disable && (cur_bit ^ cyc_cnt[1]);
                    end
                    if (cycle_end && cyc_cnt == 16'(mrr_pkg::TX_CYCLES - 1)) begin
                        o_tx_key <= 1'b0;
                        state    <= mrr_pkg::ST_IDLE;
                    end
                end
                default: state <= mrr_pkg::ST_IDLE;
            endcase
        end
    end

    // chip id goes out with the request and the message comes back with the ack
    always_ff @(posedge clk) begin
        if (state == mrr_pkg::ST_POP && !o_pop_request) begin
            o_pop_chip_id <= i_chip_id;
        end
        if (state == mrr_pkg::ST_POP && o_pop_request && i_pop_ack) begin
            message <= i_pop_message;
        end
    end

    // the queue only acknowledges a pending request
    a_ack_with_request: assert property (
        @(posedge clk) disable iff (rst)
        i_pop_ack |-> o_pop_request
    );

endmodule

`default_nettype wire

// ==== logic/mrr_loopback_top.sv ====
`default_nettype none

module mrr_loopback_top (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                i_fm_flag,
    input  wire logic                                i_sample_valid,
    input  wire logic [mrr_pkg::ESAMP_WIDTH-1:0]     i_sample,
    input  wire logic [3:0]                          i_recharge_len,
    input  wire logic                                i_tx_disable,
    input  wire logic [7:0]                          i_num_payload_bits,
    input  wire logic [15:0]                         i_wait_step,
    input  wire logic                                i_pop_ack,
    input  wire logic [mrr_pkg::MESSAGE_LEN-1:0]     i_pop_message,
    output logic                                     o_pop_request,
    output logic [mrr_pkg::CHIP_ID_LEN-1:0]          o_pop_chip_id,
    output logic                                     o_busy,
    output logic                                     o_detector_reset,
    output logic                                     o_tx_en,
    output logic                                     o_tx_key
);

    logic                               rx_en;
    logic                               buffer_full;
    logic [mrr_pkg::BIT_CNT_WIDTH-1:0]  bit_count;
    logic [mrr_pkg::CHIP_ID_LEN-1:0]    chip_id;
    logic [mrr_pkg::BUF_AWIDTH-1:0]     offset;
    logic                               offset_valid;

    decision_if dec_bus ();

    chip_demodulator u_demod (
        .clk            (clk),
        .rst            (rst),
        .i_rx_en        (rx_en),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_recharge_len (i_recharge_len),
        .dec            (dec_bus.producer),
        .o_buffer_full  (buffer_full),
        .o_bit_count    (bit_count),
        .o_chip_id      (chip_id)
    );

    decision_buffer u_buffer (
        .clk (clk),
        .bus (dec_bus.buffer)
    );

    pn_search u_search (
        .clk            (clk),
        .rst            (rst),
        .i_rx_en        (rx_en),
        .i_buffer_full  (buffer_full),
        .rd             (dec_bus.consumer),
        .o_offset       (offset),
        .o_offset_valid (offset_valid)
    );

    loopback_controller u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_fm_flag          (i_fm_flag),
        .i_sample_valid     (i_sample_valid),
        .i_tx_disable       (i_tx_disable),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_bit_count        (bit_count),
        .i_chip_id          (chip_id),
        .i_offset           (offset),
        .i_offset_valid     (offset_valid),
        .i_pop_ack          (i_pop_ack),
        .i_pop_message      (i_pop_message),
        .o_rx_en            (rx_en),
        .o_pop_request      (o_pop_request),
        .o_pop_chip_id      (o_pop_chip_id),
        .o_busy             (o_busy),
        .o_detector_reset   (o_detector_reset),
        .o_tx_en            (o_tx_en),
        .o_tx_key           (o_tx_key)
    );

endmodule

`default_nettype wire

// ==== verif/tb_mrr_loopback.sv ====
`default_nettype none

module tb_mrr_loopback;

    localparam int NUM_TESTS = 10;
    localparam int FIELDS = 9;
    localparam int PN_LEN = 15;
    localparam logic [PN_LEN-1:0] PN_CHIPS = 15'b000100110101111;
    localparam int STROBES_PER_CYCLE = 4;
    // 32 bits of 4 mrr cycles with 4 strobes per cycle
    localparam int TX_STROBES = 32 * 4 * STROBES_PER_CYCLE;
    localparam logic [15:0] AMPLITUDE = 16'd1000;
    localparam logic [31:0] SEED = 32'hb2ebd79c;

    logic        clk;
    logic        rst;
    logic        i_fm_flag;
    // driven only by the sample generator below
    logic        i_sample_valid = 1'b0;
    logic [15:0] i_sample = 16'd0;
    logic [3:0]  i_recharge_len;
    logic        i_tx_disable;
    logic [7:0]  i_num_payload_bits;
    logic [15:0] i_wait_step;
    logic        i_pop_ack;
    logic [31:0] i_pop_message;
    logic        o_pop_request;
    logic [15:0] o_pop_chip_id;
    logic        o_busy;
    logic        o_detector_reset;
    logic        o_tx_en;
    logic        o_tx_key;

    logic [31:0] stim_mem [0:NUM_TESTS*FIELDS-1];
    logic        bit_seq [0:63];
    int          n_bits;
    int          sym_strobes;
    logic        gen_on;
    int          gen_phase = 0;
    int          strobe_idx = 0;
    logic [31:0] noise_state = SEED;
    logic [31:0] delay_state = SEED;
    string       test_name;

    mrr_loopback_top i_dut (
        .clk                (clk),
        .rst                (rst),
        .i_fm_flag          (i_fm_flag),
        .i_sample_valid     (i_sample_valid),
        .i_sample           (i_sample),
        .i_recharge_len     (i_recharge_len),
        .i_tx_disable       (i_tx_disable),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_pop_ack          (i_pop_ack),
        .i_pop_message      (i_pop_message),
        .o_pop_request      (o_pop_request),
        .o_pop_chip_id      (o_pop_chip_id),
        .o_busy             (o_busy),
        .o_detector_reset   (o_detector_reset),
        .o_tx_en            (o_tx_en),
        .o_tx_key           (o_tx_key)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ook level of strobe idx counted from the first strobe of the packet
    function automatic logic [15:0] chip_level(input int idx);
        int   sym;
        int   cyc;
        logic on;
        sym = idx / sym_strobes;
        cyc = (idx % sym_strobes) / STROBES_PER_CYCLE;
        on = 1'b0;
        if (sym < n_bits) begin
            on = bit_seq[sym] ? (cyc == 5 || cyc == 6) : (cyc == 3 || cyc == 4);
        end
        chip_level = on ? AMPLITUDE : 16'd0;
    endfunction

    // one strobe every 3 clocks while enabled with noise 0..63 on every sample
    always @(posedge clk) begin
        if (!gen_on) begin
            i_sample_valid <= 1'b0;
            gen_phase      <= 0;
            strobe_idx     <= 0;
        end else if (gen_phase == 2) begin
            i_sample_valid <= 1'b1;
            i_sample       <= chip_level(strobe_idx) + {10'd0, noise_state[21:16]};
            noise_state    <= lcg_next(noise_state);
            gen_phase      <= 0;
            strobe_idx     <= strobe_idx + 1;
        end else begin
            i_sample_valid <= 1'b0;
            gen_phase      <= gen_phase + 1;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch in %s: %s expected %h actual %h",
                                    test_name, name, expected, actual));
        end
    endtask

    task automatic step_clock(inout int cnt, input int limit, input string what);
        @(negedge clk);
        cnt++;
        if (cnt > limit) begin
            stop_on_error($sformatf("timeout in %s while waiting for %s", test_name, what));
        end
    endtask

    task automatic check_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("busy while idle", 0, o_busy);
            check_value("pop_request while idle", 0, o_pop_request);
            check_value("tx_en while idle", 0, o_tx_en);
            check_value("tx_key while idle", 0, o_tx_key);
            check_value("detector_reset while idle", 0, o_detector_reset);
        end
    endtask

    task automatic run_test(input int t);
        int          base;
        int          num_payload;
        int          wait_step;
        int          lead_n;
        int          exp_offset;
        int          i;
        int          cnt;
        int          limit;
        int          delay;
        int          n;
        int          cyc;
        logic        dis;
        logic [31:0] message;
        logic [15:0] exp_id;
        logic        exp_key;
        base = t * FIELDS;
        num_payload = int'(stim_mem[base+1]);
        wait_step = int'(stim_mem[base+2]);
        dis = stim_mem[base+3][0];
        lead_n = int'(stim_mem[base+4]);
        exp_offset = int'(stim_mem[base+6]);
        message = stim_mem[base+8];
        test_name = $sformatf("test %0d", t);

        // one sequence of lead bits then the preamble msb first then the payload
        n_bits = 0;
        for (i = 0; i < lead_n; i++) begin
            bit_seq[n_bits] = stim_mem[base+5][i];
            n_bits++;
        end
        for (i = 0; i < PN_LEN; i++) begin
            bit_seq[n_bits] = PN_CHIPS[PN_LEN-1-i];
            n_bits++;
        end
        for (i = 0; i < num_payload - PN_LEN; i++) begin
            bit_seq[n_bits] = stim_mem[base+7][i];
            n_bits++;
        end
        sym_strobes = (int'(stim_mem[base]) + 3) * STROBES_PER_CYCLE;
        // id is the 16 bits ending at offset + num_payload - 1 with the newest at the msb
        for (i = 0; i < 16; i++) begin
            exp_id[i] = bit_seq[exp_offset + num_payload - 16 + i];
        end

        @(posedge clk);
        i_recharge_len     <= stim_mem[base][3:0];
        i_num_payload_bits <= num_payload[7:0];
        i_wait_step        <= wait_step[15:0];
        i_tx_disable       <= dis;
        i_fm_flag          <= 1'b1;
        @(posedge clk);
        i_fm_flag <= 1'b0;
        cnt = 0;
        do begin
            step_clock(cnt, 4, "busy after fm_flag");
        end while (o_busy !== 1'b1);
        // first strobe lands after rx is enabled
        @(posedge clk);
        gen_on <= 1'b1;

        cnt = 0;
        limit = (n_bits + 2) * sym_strobes * 3 + 1000;
        do begin
            step_clock(cnt, limit, "pop request");
            check_value("busy during rx", 1, o_busy);
            check_value("tx_en during rx", 0, o_tx_en);
            check_value("tx_key during rx", 0, o_tx_key);
        end while (o_pop_request !== 1'b1);
        check_value("pop_chip_id", exp_id, o_pop_chip_id);

        // queue answers after 0 to 20 clocks
        delay_state = lcg_next(delay_state);
        delay = int'(delay_state[23:16]) % 21;
        for (i = 0; i < delay; i++) begin
            @(negedge clk);
            check_value("pop_request held", 1, o_pop_request);
            check_value("pop_chip_id held", exp_id, o_pop_chip_id);
        end
        @(posedge clk);
        i_pop_ack     <= 1'b1;
        i_pop_message <= message;
        @(posedge clk);
        i_pop_ack     <= 1'b0;
        i_pop_message <= ~message;
        @(negedge clk);
        check_value("pop_request after ack", 0, o_pop_request);

        cnt = 0;
        limit = (wait_step + 2) * STROBES_PER_CYCLE * 3 + 20;
        while (o_detector_reset !== 1'b1) begin
            check_value("tx_en in turnaround", !dis, o_tx_en);
            step_clock(cnt, limit, "start of transmit");
        end

        // key is sampled before the third strobe of each mrr cycle
        n = 0;
        cnt = 0;
        while (n < TX_STROBES) begin
            check_value("tx_en during tx", !dis, o_tx_en);
            check_value("detector_reset during tx", 1, o_detector_reset);
            if (dis) begin
                check_value("tx_key while disabled", 0, o_tx_key);
            end
            if (i_sample_valid) begin
                if (n % STROBES_PER_CYCLE == 2) begin
                    cyc = (n / STROBES_PER_CYCLE) % 4;
                    exp_key = !dis && (message[n / 16] ? (cyc < 2) : (cyc >= 2));
                    check_value($sformatf("tx_key of bit %0d cycle %0d", n / 16, cyc),
                                exp_key, o_tx_key);
                end
                n++;
            end
            step_clock(cnt, TX_STROBES * 3 + 20, "end of transmit");
        end

        cnt = 0;
        while (o_busy !== 1'b0) begin
            step_clock(cnt, 8, "busy to fall");
        end
        check_value("tx_key after tx", 0, o_tx_key);
        check_value("tx_en after tx", 0, o_tx_en);
        @(posedge clk);
        gen_on <= 1'b0;
    endtask

    initial begin
        int t;
        rst                <= 1'b1;
        i_fm_flag          <= 1'b0;
        i_recharge_len     <= 4'd5;
        i_tx_disable       <= 1'b0;
        i_num_payload_bits <= 8'd0;
        i_wait_step        <= 16'd0;
        i_pop_ack          <= 1'b0;
        i_pop_message      <= 32'd0;
        gen_on             <= 1'b0;
        test_name = "reset";
        $readmemh("verif/loopback_stim.txt", stim_mem);
        if ($isunknown(stim_mem[NUM_TESTS*FIELDS-1])) begin
            stop_on_error("stimulus file verif/loopback_stim.txt is missing or too short");
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        check_idle(20);
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
            check_idle(10);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/loopback_stim.txt ====
// recharge_len num_payload_bits wait_step tx_disable lead_count lead_word offset payload message
// all fields hex; lead and payload bits are sent lsb first
5 2f 3 0 0 00 0 a5c31e7b 12345678
6 2f 8 0 3 05 3 3c9e0f12 deadbeef
5 28 1 0 8 b4 8 71f0c2a9 0f0f00ff
7 2f 14 1 2 02 2 9e24b6d1 cafef00d
9 2a 5 0 5 1b 5 0123abcd 80000001
5 2f a 0 7 6e 7 fedc4321 5a5aa5a5
8 2f 2 1 1 01 1 55aa33cc 13579bdf
6 2c 6 0 4 09 4 c0ffee11 ffffffff
5 2f 4 0 6 2d 6 8badf00d 00000000
a 2f 7 0 8 ff 8 468ace02 76543210

// ==== files.f ====
common/mrr_pkg.sv
common/decision_if.sv
demod/chip_demodulator.sv
logic/decision_buffer.sv
logic/pn_search.sv
loopback/loopback_controller.sv
logic/mrr_loopback_top.sv
verif/tb_mrr_loopback.sv

// ==== Makefile ====
TOP := tb_mrr_loopback
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || { echo "test FAILED"; exit 1; }
	@echo "test PASSED"

clean:
	rm -rf obj_dir $(LOG)
